//--- include/rvCoreParams.svh
/* Core-wide constants for the RV32I multi-cycle core.
   Included by the package and by the RTL units that need them. */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// PC value after reset
`define RV_RESET_ADDR 32'h0000_0000
// Internal address bus width
`define RV_ADDR_WIDTH 24
`define RV_NUM_REGS 32

// Opcode classes, instruction bits 6 down to 2
`define RV_OP_LOAD   5'b00000
`define RV_OP_ALUIMM 5'b00100
`define RV_OP_AUIPC  5'b00101
`define RV_OP_STORE  5'b01000
`define RV_OP_ALUREG 5'b01100
`define RV_OP_LUI    5'b01101
`define RV_OP_BRANCH 5'b11000
`define RV_OP_JALR   5'b11001
`define RV_OP_JAL    5'b11011

`endif

//--- hdl/rvCorePkg.sv
/* Shared types of the RV32I core: word and address widths, instruction fields
   and the control state encoding. Referenced by scoped name only. */
`include "rvCoreParams.svh"

package rvCorePkg;

   // Data word as seen on the register file and memory bus
   typedef logic [31:0] word_t;

   // Internal address, narrower than a word
   typedef logic [`RV_ADDR_WIDTH-1:0] addr_t;

   // Register index and instruction fields
   typedef logic [4:0] regIdx_t;
   typedef logic [2:0] funct3_t;
   typedef logic [4:0] shamt_t;

   // Control states, one bit per state
   typedef enum logic [4:0] {
      FETCH_INSTR     = 5'b00001,
      WAIT_INSTR      = 5'b00010,
      EXECUTE1        = 5'b00100,
      EXECUTE2        = 5'b01000,
      WAIT_ALU_OR_MEM = 5'b10000
   } coreState_t;

endpackage

//--- hdl/decodedInstrIf.sv
/* Decoded fields of the instruction being executed. Driven by the decoder,
   read by the ALU and by the control unit. */
`timescale 1ns/100ps

interface decodedInstrIf;

   // Destination register and function field
   rvCorePkg::regIdx_t rdId;
   rvCorePkg::funct3_t funct3;

   // Instruction bit 30 selects SUB and SRA, bit 5 tells register ops from immediates
   logic instr30;
   logic instr5;

   // Opcode class, at most one high
   logic isLoad;
   logic isStore;
   logic isAluReg;
   logic isAluImm;
   logic isBranch;
   logic isJal;
   logic isJalr;
   logic isLui;
   logic isAuipc;

   // Immediate formats
   rvCorePkg::word_t iImm;
   rvCorePkg::word_t sImm;
   rvCorePkg::word_t bImm;
   rvCorePkg::word_t jImm;
   rvCorePkg::word_t uImm;

   modport producer (
      output rdId, funct3, instr30, instr5,
      output isLoad, isStore, isAluReg, isAluImm, isBranch, isJal, isJalr, isLui, isAuipc,
      output iImm, sImm, bImm, jImm, uImm
   );

   modport aluSide (
      input funct3, instr30, instr5, isAluReg, isBranch, iImm
   );

   modport ctrlSide (
      input funct3,
      input isLoad, isStore, isAluReg, isAluImm, isBranch, isJal, isJalr, isLui, isAuipc,
      input iImm, sImm, bImm, jImm, uImm
   );

endinterface

//--- hdl/rvDecoder.sv
/* Instruction register and decoder. Latches the fetched word on instrLoad
   and presents opcode class, fields and immediates on the decoded interface. */
`timescale 1ns/100ps
`include "rvCoreParams.svh"

module rvDecoder (
   input  logic                clk,
   input  logic                instrLoad,
   input  rvCorePkg::word_t    memRData,
   decodedInstrIf.producer     dec
);

   // Bits 1:0 are always 2'b11 in RV32I
   logic [31:2] instr;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRData[31:2];
      end
   end

   assign dec.rdId    = instr[11:7];
   assign dec.funct3  = instr[14:12];
   assign dec.instr30 = instr[30];
   assign dec.instr5  = instr[5];

   // Opcode class from bits 6:2
   assign dec.isLoad   = (instr[6:2] == `RV_OP_LOAD);
   assign dec.isAluImm = (instr[6:2] == `RV_OP_ALUIMM);
   assign dec.isAuipc  = (instr[6:2] == `RV_OP_AUIPC);
   assign dec.isStore  = (instr[6:2] == `RV_OP_STORE);
   assign dec.isAluReg = (instr[6:2] == `RV_OP_ALUREG);
   assign dec.isLui    = (instr[6:2] == `RV_OP_LUI);
   assign dec.isBranch = (instr[6:2] == `RV_OP_BRANCH);
   assign dec.isJalr   = (instr[6:2] == `RV_OP_JALR);
   assign dec.isJal    = (instr[6:2] == `RV_OP_JAL);

   // Immediates, all sign extended from bit 31
   assign dec.uImm = {instr[31:12], 12'b0};
   assign dec.iImm = {{21{instr[31]}}, instr[30:20]};
   assign dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // A freshly loaded word never decodes to two classes
   assert property (@(posedge clk) instrLoad |=> $onehot0({dec.isLoad, dec.isAluImm,
      dec.isAuipc, dec.isStore, dec.isAluReg, dec.isLui, dec.isBranch, dec.isJalr,
      dec.isJal}));

endmodule

//--- hdl/rvRegFile.sv
/* General purpose register file. Both sources are read from the raw fetched
   word when the instruction is latched; one write port on the clock edge. */
`timescale 1ns/100ps
`include "rvCoreParams.svh"

module rvRegFile (
   input  logic                clk,
   input  logic                instrLoad,
   input  rvCorePkg::word_t    memRData,
   input  logic                writeEn,
   input  rvCorePkg::regIdx_t  rdId,
   input  rvCorePkg::word_t    writeData,
   output rvCorePkg::word_t    rs1,
   output rvCorePkg::word_t    rs2
);

   rvCorePkg::word_t regs [`RV_NUM_REGS];

   // Source indices straight from the incoming word
   rvCorePkg::regIdx_t rs1Id;
   rvCorePkg::regIdx_t rs2Id;

   assign rs1Id = memRData[19:15];
   assign rs2Id = memRData[24:20];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (writeEn && rdId != '0) begin
         regs[rdId] <= writeData;
      end
   end

   // Reads of x0 return zero whatever the array holds
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

//--- hdl/rvAlu.sv
/* Integer ALU. Results are registered on aluStart; shifts go one bit per
   cycle and hold aluBusy high until done. Comparisons feed the branch logic. */
`timescale 1ns/100ps

module rvAlu (
   input  logic                clk,
   input  logic                aluStart,
   decodedInstrIf.aluSide      dec,
   input  rvCorePkg::word_t    rs1,
   input  rvCorePkg::word_t    rs2,
   output rvCorePkg::word_t    aluOut,
   output rvCorePkg::word_t    aluPlus,
   output logic                lt,
   output logic                ltu,
   output logic                eq,
   output logic                aluBusy
);

   rvCorePkg::word_t aluIn1;
   rvCorePkg::word_t aluIn2;
   logic [32:0]      aluMinus;
   logic             isShift;

   // Holds the result, and the operand while a shift is running
   rvCorePkg::word_t aluReg;
   // Remaining shift positions, idle at power-up
   rvCorePkg::shamt_t shiftCount = '0;

   assign aluIn1 = rs1;
   // rs2 for register ops and branches, I-immediate for the rest
   assign aluIn2 = (dec.isAluReg || dec.isBranch) ? rs2 : dec.iImm;

   // The adder also serves JALR targets
   assign aluPlus = aluIn1 + aluIn2;

   // One 33-bit subtract for SUB and all three compares
   assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[32];
   // Signs differ: rs1 negative means less
   assign lt       = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == '0);

   // SLL is funct3 001, SRL and SRA are 101
   assign isShift = (dec.funct3 == 3'b001) || (dec.funct3 == 3'b101);
   assign aluBusy = |shiftCount;
   assign aluOut  = aluReg;

   always_ff @(posedge clk) begin
      if (aluStart) begin
         shiftCount <= isShift ? aluIn2[4:0] : '0;
         case (dec.funct3)
            // SUB only for the register form, bit 30 is immediate data in ADDI
            3'b000:  aluReg <= (dec.instr30 && dec.instr5) ? aluMinus[31:0] : aluPlus;
            3'b010:  aluReg <= {31'b0, lt};
            3'b011:  aluReg <= {31'b0, ltu};
            3'b100:  aluReg <= aluIn1 ^ aluIn2;
            3'b110:  aluReg <= aluIn1 | aluIn2;
            3'b111:  aluReg <= aluIn1 & aluIn2;
            // Shifts start from the unshifted operand
            default: aluReg <= aluIn1;
         endcase
      end else if (aluBusy) begin
         shiftCount <= shiftCount - 5'd1;
         if (dec.funct3 == 3'b001) begin
            aluReg <= {aluReg[30:0], 1'b0};
         end else begin
            // Fill with the sign bit for SRA only
            aluReg <= {dec.instr30 & aluReg[31], aluReg[31:1]};
         end
      end
   end

   // Control must wait out a running shift before starting another op
   assert property (@(posedge clk) aluBusy |-> !aluStart);

endmodule

//--- hdl/rvControl.sv
/* Control unit of the multi-cycle core. Runs the five-state sequence, owns the
   PC and address adders, drives the shared memory port and selects write-back. */
`timescale 1ns/100ps
`include "rvCoreParams.svh"

module rvControl (
   input  logic                clk,
   input  logic                reset,
   decodedInstrIf.ctrlSide     dec,
   input  rvCorePkg::word_t    rs1,
   input  rvCorePkg::word_t    rs2,
   input  rvCorePkg::word_t    aluOut,
   input  rvCorePkg::word_t    aluPlus,
   input  logic                lt,
   input  logic                ltu,
   input  logic                eq,
   input  logic                aluBusy,
   input  rvCorePkg::word_t    memRData,
   input  logic                memRBusy,
   input  logic                memWBusy,
   output logic                instrLoad,
   output logic                aluStart,
   output logic                writeEn,
   output rvCorePkg::word_t    writeData,
   output rvCorePkg::word_t    memAddr,
   output rvCorePkg::word_t    memWData,
   output logic [3:0]          memWMask,
   output logic                memRStrb
);

   rvCorePkg::coreState_t state;

   // Set once an instruction has been latched since reset
   logic haveInstr;

   rvCorePkg::addr_t pc;
   rvCorePkg::addr_t pcPlus4;
   // Target for branches, JAL and AUIPC
   rvCorePkg::addr_t pcPlusImm;
   rvCorePkg::addr_t loadStoreAddr;

   rvCorePkg::word_t pcImm;
   rvCorePkg::word_t lsImm;
   logic             predicateNext;
   logic             predicate;
   logic             jumpToTarget;
   logic             needToWait;
   logic             fetchPhase;

   assign pcPlus4 = pc + 4;

   // J immediate for JAL, U for AUIPC and B for branches
   assign pcImm = dec.isJal ? dec.jImm : (dec.isAuipc ? dec.uImm : dec.bImm);
   assign lsImm = dec.isStore ? dec.sImm : dec.iImm;

   always_comb begin
      case (dec.funct3)
         3'b000:  predicateNext = eq;
         3'b001:  predicateNext = !eq;
         3'b100:  predicateNext = lt;
         3'b101:  predicateNext = !lt;
         3'b110:  predicateNext = ltu;
         3'b111:  predicateNext = !ltu;
         default: predicateNext = 1'b0;
      endcase
   end

   assign jumpToTarget = dec.isJal || (dec.isBranch && predicate);
   // Loads and stores always wait for the memory
   assign needToWait   = dec.isLoad || dec.isStore || aluBusy;

   // Memory port
   assign fetchPhase = (state == rvCorePkg::FETCH_INSTR) || (state == rvCorePkg::WAIT_INSTR);
   assign memAddr    = rvCorePkg::word_t'(fetchPhase ? pc : loadStoreAddr);
   assign memWData   = rs2;
   assign memRStrb   = (state == rvCorePkg::FETCH_INSTR) ||
                       (state == rvCorePkg::EXECUTE2 && dec.isLoad);
   assign memWMask   = {4{state == rvCorePkg::EXECUTE2 && dec.isStore}};

   // Unit strobes
   assign instrLoad = (state == rvCorePkg::WAIT_INSTR) && !memRBusy;
   assign aluStart  = (state == rvCorePkg::EXECUTE1) && (dec.isAluReg || dec.isAluImm);
   assign writeEn   = haveInstr && !(dec.isBranch || dec.isStore) &&
                      (state == rvCorePkg::EXECUTE2 || state == rvCorePkg::WAIT_ALU_OR_MEM);

   // Load data is written back when no other source matches
   always_comb begin
      if (dec.isLui) begin
         writeData = dec.uImm;
      end else if (dec.isAluReg || dec.isAluImm) begin
         writeData = aluOut;
      end else if (dec.isAuipc) begin
         writeData = rvCorePkg::word_t'(pcPlusImm);
      end else if (dec.isJal || dec.isJalr) begin
         // Return address
         writeData = rvCorePkg::word_t'(pcPlus4);
      end else begin
         writeData = memRData;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for the memory to go idle
         state     <= rvCorePkg::WAIT_ALU_OR_MEM;
         pc        <= rvCorePkg::addr_t'(`RV_RESET_ADDR);
         haveInstr <= 1'b0;
      end else begin
         unique case (state)
            rvCorePkg::WAIT_INSTR: begin
               if (!memRBusy) begin
                  haveInstr <= 1'b1;
                  state     <= rvCorePkg::EXECUTE1;
               end
            end
            rvCorePkg::EXECUTE1: begin
               state <= rvCorePkg::EXECUTE2;
            end
            rvCorePkg::EXECUTE2: begin
               // JALR target has bit zero cleared
               if (dec.isJalr) begin
                  pc <= {aluPlus[`RV_ADDR_WIDTH-1:1], 1'b0};
               end else if (jumpToTarget) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? rvCorePkg::WAIT_ALU_OR_MEM : rvCorePkg::FETCH_INSTR;
            end
            rvCorePkg::WAIT_ALU_OR_MEM: begin
               if (!aluBusy && !memRBusy && !memWBusy) begin
                  state <= rvCorePkg::FETCH_INSTR;
               end
            end
            default: begin
               state <= rvCorePkg::WAIT_INSTR;
            end
         endcase
      end
   end

   // Address adders and branch decision are registered in EXECUTE1
   always_ff @(posedge clk) begin
      if (state == rvCorePkg::EXECUTE1) begin
         pcPlusImm     <= pc + pcImm[`RV_ADDR_WIDTH-1:0];
         loadStoreAddr <= rs1[`RV_ADDR_WIDTH-1:0] + lsImm[`RV_ADDR_WIDTH-1:0];
         predicate     <= predicateNext;
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state));

   // Fetch and data access share one port and never overlap
   assert property (@(posedge clk) disable iff (!reset) !(memRStrb && (|memWMask)));

endmodule

//--- hdl/rvCoreTop.sv
/* Top level of the RV32I core with one shared memory port.
   Wires the decoder, register file, ALU and control unit together. */
`timescale 1ns/100ps

module rvCoreTop (
   input  logic              clk,
   input  logic              reset,
   output rvCorePkg::word_t  memAddr,
   output rvCorePkg::word_t  memWData,
   output logic [3:0]        memWMask,
   input  rvCorePkg::word_t  memRData,
   output logic              memRStrb,
   input  logic              memRBusy,
   input  logic              memWBusy
);

   decodedInstrIf decIf ();

   logic             instrLoad;
   logic             aluStart;
   logic             aluBusy;
   logic             writeEn;
   rvCorePkg::word_t writeData;
   rvCorePkg::word_t rs1;
   rvCorePkg::word_t rs2;
   rvCorePkg::word_t aluOut;
   rvCorePkg::word_t aluPlus;
   logic             lt;
   logic             ltu;
   logic             eq;

   rvDecoder decoderInst (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRData  (memRData),
      .dec       (decIf.producer)
   );

   // Destination index comes straight off the decoded fields
   rvRegFile regFileInst (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRData  (memRData),
      .writeEn   (writeEn),
      .rdId      (decIf.rdId),
      .writeData (writeData),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   rvAlu aluInst (
      .clk      (clk),
      .aluStart (aluStart),
      .dec      (decIf.aluSide),
      .rs1      (rs1),
      .rs2      (rs2),
      .aluOut   (aluOut),
      .aluPlus  (aluPlus),
      .lt       (lt),
      .ltu      (ltu),
      .eq       (eq),
      .aluBusy  (aluBusy)
   );

   rvControl controlInst (
      .clk       (clk),
      .reset     (reset),
      .dec       (decIf.ctrlSide),
      .rs1       (rs1),
      .rs2       (rs2),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .lt        (lt),
      .ltu       (ltu),
      .eq        (eq),
      .aluBusy   (aluBusy),
      .memRData  (memRData),
      .memRBusy  (memRBusy),
      .memWBusy  (memWBusy),
      .instrLoad (instrLoad),
      .aluStart  (aluStart),
      .writeEn   (writeEn),
      .writeData (writeData),
      .memAddr   (memAddr),
      .memWData  (memWData),
      .memWMask  (memWMask),
      .memRStrb  (memRStrb)
   );

endmodule

//--- bench/tbMemory.sv
/* Behavioral word memory for the core testbench. Answers read strobes and
   writes with random busy delays, and logs every store for the checks. */
`timescale 1ns/100ps

module tbMemory (
   input  logic              clk,
   input  rvCorePkg::word_t  memAddr,
   input  rvCorePkg::word_t  memWData,
   input  logic [3:0]        memWMask,
   input  logic              memRStrb,
   output rvCorePkg::word_t  memRData,
   output logic              memRBusy,
   output logic              memWBusy
);

   // 4 KB of words, indexed by address bits 11:2
   rvCorePkg::word_t words [1024];

   // Store log, one entry per write cycle
   logic [31:0]      logAddr [$];
   rvCorePkg::word_t logData [$];

   integer seed = 32'habce;
   int     readCount = 0;
   int     writeCount = 0;

   initial begin
      memRData = '0;
      memRBusy = 1'b0;
      memWBusy = 1'b0;
   end

   // Read side, data is ready at once and busy hides it for 0 to 3 cycles
   always @(posedge clk) begin
      if (memRStrb === 1'b1) begin
         memRData  <= words[memAddr[11:2]];
         readCount = $random(seed) & 3;
         memRBusy  <= (readCount != 0);
      end else if (readCount != 0) begin
         readCount = readCount - 1;
         memRBusy  <= (readCount != 0);
      end
   end

   // Write side, the mask is either all bytes or none
   always @(posedge clk) begin
      if (memWMask === 4'hf) begin
         words[memAddr[11:2]] <= memWData;
         logAddr.push_back(memAddr);
         logData.push_back(memWData);
         writeCount = $random(seed) & 3;
         memWBusy   <= (writeCount != 0);
      end else if (writeCount != 0) begin
         writeCount = writeCount - 1;
         memWBusy   <= (writeCount != 0);
      end
   end

endmodule

//--- bench/rvCoreTb.sv
/* Directed testbench for the RV32I core. Each test assembles a small program,
   runs it until the marker store and checks the stores the program made. */
`timescale 1ns/100ps
`include "rvCoreParams.svh"

module rvCoreTb;

   localparam int RUN_LIMIT = 3000;
   localparam logic [31:0] MARKER_ADDR = 32'h100;

   logic             clk;
   logic             reset;
   rvCorePkg::word_t memAddr;
   rvCorePkg::word_t memWData;
   rvCorePkg::word_t memRData;
   logic [3:0]       memWMask;
   logic             memRStrb;
   logic             memRBusy;
   logic             memWBusy;

   // Program under construction and the stores it must produce
   rvCorePkg::word_t prog [$];
   logic [31:0]      expAddr [$];
   rvCorePkg::word_t expData [$];
   logic [31:0]      resAddr;

   string testName;
   int    errs;
   int    passCount = 0;
   int    failCount = 0;

   rvCoreTop rvCoreTop_inst (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWData (memWData),
      .memWMask (memWMask),
      .memRData (memRData),
      .memRStrb (memRStrb),
      .memRBusy (memRBusy),
      .memWBusy (memWBusy)
   );

   tbMemory mem (
      .clk      (clk),
      .memAddr  (memAddr),
      .memWData (memWData),
      .memWMask (memWMask),
      .memRStrb (memRStrb),
      .memRData (memRData),
      .memRBusy (memRBusy),
      .memWBusy (memWBusy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Instruction encoders, one per RV32I format
   function automatic rvCorePkg::word_t encR(logic [6:0] f7, rvCorePkg::regIdx_t rs2,
      rvCorePkg::regIdx_t rs1, rvCorePkg::funct3_t f3, rvCorePkg::regIdx_t rd);
      return {f7, rs2, rs1, f3, rd, `RV_OP_ALUREG, 2'b11};
   endfunction

   function automatic rvCorePkg::word_t encI(rvCorePkg::word_t imm, rvCorePkg::regIdx_t rs1,
      rvCorePkg::funct3_t f3, rvCorePkg::regIdx_t rd, logic [4:0] op);
      return {imm[11:0], rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic rvCorePkg::word_t encS(rvCorePkg::word_t imm, rvCorePkg::regIdx_t rs2,
      rvCorePkg::regIdx_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE, 2'b11};
   endfunction

   function automatic rvCorePkg::word_t encB(rvCorePkg::word_t imm, rvCorePkg::regIdx_t rs2,
      rvCorePkg::regIdx_t rs1, rvCorePkg::funct3_t f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH, 2'b11};
   endfunction

   function automatic rvCorePkg::word_t encU(rvCorePkg::word_t imm, rvCorePkg::regIdx_t rd,
      logic [4:0] op);
      return {imm[31:12], rd, op, 2'b11};
   endfunction

   function automatic rvCorePkg::word_t encJ(rvCorePkg::word_t imm, rvCorePkg::regIdx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL, 2'b11};
   endfunction

   // Byte address of the next instruction to be emitted
   function automatic rvCorePkg::word_t pcHere();
      return `RV_RESET_ADDR + prog.size() * 4;
   endfunction

   // Branch outcome by the RV32I rules
   function automatic bit takenByRule(rvCorePkg::funct3_t f3, rvCorePkg::word_t a,
      rvCorePkg::word_t b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic bit markerSeen();
      foreach (mem.logAddr[i]) begin
         if (mem.logAddr[i] == MARKER_ADDR) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic reportError(string msg);
      $display("ERROR at %0t: %s: %s", $time, testName, msg);
      errs++;
   endtask

   task automatic emit(rvCorePkg::word_t instr);
      prog.push_back(instr);
   endtask

   task automatic expectStore(logic [31:0] addr, rvCorePkg::word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic addi(rvCorePkg::regIdx_t rd, rvCorePkg::regIdx_t rs1, rvCorePkg::word_t imm);
      emit(encI(imm, rs1, 3'b000, rd, `RV_OP_ALUIMM));
   endtask

   // Upper part rounded so the signed low part lands on the value
   task automatic loadConst(rvCorePkg::regIdx_t rd, rvCorePkg::word_t value);
      emit(encU(value + 32'h800, rd, `RV_OP_LUI));
      addi(rd, rd, value);
   endtask

   task automatic storeWord(rvCorePkg::regIdx_t rs2, rvCorePkg::word_t off,
      rvCorePkg::regIdx_t base);
      emit(encS(off, rs2, base));
   endtask

   task automatic loadWord(rvCorePkg::regIdx_t rd, rvCorePkg::word_t off,
      rvCorePkg::regIdx_t base);
      emit(encI(off, base, 3'b010, rd, `RV_OP_LOAD));
   endtask

   // Store a register to the next result slot and expect a value there
   task automatic storeRes(rvCorePkg::regIdx_t rs2, rvCorePkg::word_t value);
      storeWord(rs2, resAddr, 0);
      expectStore(resAddr, value);
      resAddr += 4;
   endtask

   task automatic rAlu(logic [6:0] f7, rvCorePkg::funct3_t f3, rvCorePkg::regIdx_t rd,
      rvCorePkg::regIdx_t rs1, rvCorePkg::regIdx_t rs2, rvCorePkg::word_t expected);
      emit(encR(f7, rs2, rs1, f3, rd));
      storeRes(rd, expected);
   endtask

   task automatic iAlu(rvCorePkg::word_t imm, rvCorePkg::funct3_t f3, rvCorePkg::regIdx_t rd,
      rvCorePkg::regIdx_t rs1, rvCorePkg::word_t expected);
      emit(encI(imm, rs1, f3, rd, `RV_OP_ALUIMM));
      storeRes(rd, expected);
   endtask

   task automatic beginProgram(string name);
      testName = name;
      errs = 0;
      prog.delete();
      expAddr.delete();
      expData.delete();
      resAddr = 32'h200;
   endtask

   // Marker store, then a jump to itself
   task automatic endProgram();
      storeWord(0, MARKER_ADDR, 0);
      expectStore(MARKER_ADDR, 32'h0);
      emit(encJ(32'h0, 0));
   endtask

   task automatic holdReset();
      @(posedge clk);
      reset <= 1'b0;
      repeat (8) @(posedge clk);
   endtask

   // Fill pattern covers every address bit, then the program on top
   task automatic loadMemory();
      @(negedge clk);
      for (int i = 0; i < 1024; i++) begin
         mem.words[i] = 32'h5a5a_0000 ^ (i << 16) ^ i;
      end
      foreach (prog[i]) begin
         mem.words[((`RV_RESET_ADDR >> 2) + i) % 1024] = prog[i];
      end
      mem.logAddr.delete();
      mem.logData.delete();
   endtask

   task automatic releaseAndWait();
      int  cycles;
      bit  sawStrobe;
      cycles = 0;
      sawStrobe = 1'b0;
      @(posedge clk);
      reset <= 1'b1;
      // No write before the first fetch, which goes to the reset address
      while (!sawStrobe && cycles < 50) begin
         @(negedge clk);
         cycles++;
         if (memWMask != 4'h0) begin
            reportError("write mask active before the first fetch");
         end
         if (memRStrb === 1'b1) begin
            sawStrobe = 1'b1;
            if (memAddr != `RV_RESET_ADDR) begin
               reportError($sformatf("first fetch at %h, expected %h", memAddr,
                  `RV_RESET_ADDR));
            end
         end
      end
      if (!sawStrobe) begin
         $display("%s: the core never fetched after reset", testName);
         errs++;
      end
      while (!markerSeen() && cycles < RUN_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!markerSeen()) begin
         $display("%s: the program never reached its marker store", testName);
         errs++;
      end
   endtask

   task automatic compareStores();
      int n;
      n = (mem.logAddr.size() < expAddr.size()) ? mem.logAddr.size() : expAddr.size();
      if (mem.logAddr.size() != expAddr.size()) begin
         reportError($sformatf("expected %0d stores, logged %0d", expAddr.size(),
            mem.logAddr.size()));
      end
      for (int i = 0; i < n; i++) begin
         if (mem.logAddr[i] != expAddr[i] || mem.logData[i] != expData[i]) begin
            reportError($sformatf("store %0d: expected [%h]=%h, got [%h]=%h", i, expAddr[i],
               expData[i], mem.logAddr[i], mem.logData[i]));
         end
      end
      // Memory must hold the final value of every stored word
      foreach (expAddr[i]) begin
         if (mem.words[expAddr[i][11:2]] != expData[i]) begin
            reportError($sformatf("memory at %h holds %h, expected %h", expAddr[i],
               mem.words[expAddr[i][11:2]], expData[i]));
         end
      end
   endtask

   task automatic runProgram();
      holdReset();
      loadMemory();
      releaseAndWait();
      compareStores();
   endtask

   task automatic finishTest();
      if (errs == 0) begin
         passCount++;
         $display("PASS %s", testName);
      end else begin
         failCount++;
         $display("FAIL %s with %0d errors", testName, errs);
      end
   endtask

   task automatic testReset();
      beginProgram("reset");
      addi(1, 0, 32'h123);
      storeRes(1, 32'h123);
      endProgram();
      runProgram();
      finishTest();
   endtask

   task automatic testArith();
      rvCorePkg::word_t a;
      rvCorePkg::word_t b;
      rvCorePkg::word_t c;
      rvCorePkg::word_t d;
      a = 32'h7fff_ffff;
      b = 32'h8000_0000;
      c = 32'hffff_ffff;
      d = 32'h5;
      beginProgram("arithmetic and logic");
      loadConst(1, a);
      loadConst(2, b);
      loadConst(3, c);
      addi(4, 0, d);
      iAlu(32'h1, 3'b000, 5, 1, a + 1);
      iAlu(32'hffff_ffff, 3'b000, 6, 2, b - 1);
      rAlu(7'h00, 3'b000, 7, 1, 2, a + b);
      rAlu(7'h00, 3'b000, 8, 3, 4, c + d);
      rAlu(7'h20, 3'b000, 9, 2, 1, b - a);
      rAlu(7'h20, 3'b000, 10, 4, 3, d - c);
      rAlu(7'h00, 3'b100, 11, 1, 3, a ^ c);
      rAlu(7'h00, 3'b110, 12, 2, 4, b | d);
      rAlu(7'h00, 3'b111, 13, 3, 1, c & a);
      rAlu(7'h00, 3'b010, 14, 2, 1, rvCorePkg::word_t'($signed(b) < $signed(a)));
      rAlu(7'h00, 3'b010, 15, 1, 2, rvCorePkg::word_t'($signed(a) < $signed(b)));
      rAlu(7'h00, 3'b011, 16, 2, 1, rvCorePkg::word_t'(b < a));
      rAlu(7'h00, 3'b011, 17, 4, 3, rvCorePkg::word_t'(d < c));
      iAlu(32'h0, 3'b010, 18, 3, rvCorePkg::word_t'($signed(c) < 0));
      iAlu(32'hffff_ffff, 3'b011, 19, 4, rvCorePkg::word_t'(d < 32'hffff_ffff));
      // Register zero ignores the write
      iAlu(32'h7, 3'b000, 0, 1, 32'h0);
      endProgram();
      runProgram();
      finishTest();
   endtask

   task automatic testShifts();
      rvCorePkg::word_t v;
      int amounts [4];
      v = 32'h8000_0f01;
      amounts = '{0, 1, 17, 31};
      beginProgram("shifts");
      loadConst(1, v);
      foreach (amounts[i]) begin
         addi(2, 0, amounts[i]);
         rAlu(7'h00, 3'b001, 3, 1, 2, v << amounts[i]);
         rAlu(7'h00, 3'b101, 3, 1, 2, v >> amounts[i]);
         rAlu(7'h20, 3'b101, 3, 1, 2, rvCorePkg::word_t'($signed(v) >>> amounts[i]));
         iAlu(amounts[i], 3'b001, 3, 1, v << amounts[i]);
         iAlu(amounts[i], 3'b101, 3, 1, v >> amounts[i]);
         // Bit 10 of the immediate is instruction bit 30
         iAlu(32'h400 | amounts[i], 3'b101, 3, 1,
            rvCorePkg::word_t'($signed(v) >>> amounts[i]));
      end
      endProgram();
      runProgram();
      finishTest();
   endtask

   task automatic testLoadStore();
      rvCorePkg::word_t v;
      rvCorePkg::word_t preset;
      v = 32'hcafe_f00d;
      preset = 32'h1234_5678;
      beginProgram("loads and stores");
      loadConst(1, v);
      addi(5, 0, 32'h300);
      storeWord(1, 0, 5);
      expectStore(32'h300, v);
      loadWord(2, 0, 5);
      addi(2, 2, 32'hffff_ffff);
      storeWord(2, 4, 5);
      expectStore(32'h304, v - 1);
      loadWord(3, 4, 5);
      emit(encR(7'h00, 2, 3, 3'b000, 3));
      storeWord(3, 8, 5);
      expectStore(32'h308, (v - 1) * 2);
      // Word placed before the run starts
      loadWord(4, 12, 5);
      storeWord(4, 16, 5);
      expectStore(32'h310, preset);
      endProgram();
      holdReset();
      loadMemory();
      mem.words[32'h30c >> 2] = preset;
      releaseAndWait();
      compareStores();
      finishTest();
   endtask

   task automatic testBranches();
      rvCorePkg::funct3_t conds [6];
      rvCorePkg::regIdx_t ra;
      rvCorePkg::regIdx_t rb;
      rvCorePkg::word_t   regVal [3];
      conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      regVal = '{32'h0, 32'hffff_ffff, 32'h1};
      beginProgram("branches");
      addi(1, 0, 32'hffff_ffff);
      addi(2, 0, 32'h1);
      // Taken and fall-through markers
      addi(3, 0, 32'h7a);
      addi(4, 0, 32'h4e);
      foreach (conds[i]) begin
         for (int k = 0; k < 2; k++) begin
            ra = (k == 0) ? 1 : ((conds[i][2]) ? 2 : 1);
            rb = (k == 0) ? 2 : 1;
            emit(encB(32'd12, rb, ra, conds[i]));
            storeWord(4, resAddr, 0);
            emit(encJ(32'd8, 0));
            storeWord(3, resAddr, 0);
            expectStore(resAddr,
               takenByRule(conds[i], regVal[ra], regVal[rb]) ? 32'h7a : 32'h4e);
            resAddr += 4;
         end
      end
      endProgram();
      runProgram();
      finishTest();
   endtask

   task automatic testJumps();
      rvCorePkg::word_t addrMask;
      rvCorePkg::word_t pc;
      addrMask = (32'h1 << `RV_ADDR_WIDTH) - 1;
      beginProgram("upper immediates and jumps");
      emit(encU(32'habcd_e000, 1, `RV_OP_LUI));
      storeRes(1, 32'habcd_e000);
      pc = pcHere();
      emit(encU(32'h0000_3000, 2, `RV_OP_AUIPC));
      storeRes(2, (pc + 32'h3000) & addrMask);
      // Negative offset wraps within the address width
      pc = pcHere();
      emit(encU(32'hffff_f000, 2, `RV_OP_AUIPC));
      storeRes(2, (pc + 32'hffff_f000) & addrMask);
      pc = pcHere();
      emit(encJ(32'd8, 3));
      storeWord(1, 32'h1f0, 0);
      storeRes(3, pc + 4);
      // JALR target with bit zero set in the register
      pc = pcHere();
      addi(5, 0, pc + 13);
      emit(encI(32'h0, 5, 3'b000, 6, `RV_OP_JALR));
      storeWord(1, 32'h1f4, 0);
      storeRes(6, pc + 8);
      // Odd sum from base plus immediate
      pc = pcHere();
      addi(5, 0, pc + 10);
      emit(encI(32'h3, 5, 3'b000, 7, `RV_OP_JALR));
      storeWord(1, 32'h1f8, 0);
      storeRes(7, pc + 8);
      endProgram();
      runProgram();
      finishTest();
   endtask

   // Six tests of under 64 instructions, each at most ~3000 cycles with waits
   initial begin
      repeat (20000) @(posedge clk);
      $display("Watchdog: the run did not finish within 20000 cycles and was stopped");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      reset = 1'b0;
      testReset();
      testArith();
      testShifts();
      testLoadStore();
      testBranches();
      testJumps();
      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- rvCoreTop.f
+incdir+include
hdl/rvCorePkg.sv
hdl/decodedInstrIf.sv
hdl/rvDecoder.sv
hdl/rvRegFile.sv
hdl/rvAlu.sv
hdl/rvControl.sv
hdl/rvCoreTop.sv
bench/tbMemory.sv
bench/rvCoreTb.sv
